// File: verilog/vote_cfg_pkg.sv
package vote_cfg_pkg;

    // default number of reporting cores
    parameter int def_core_num = 16;

    // cores per adder group, must divide def_core_num
    parameter int def_group_size = 4;

    // accumulator width
    // 30 signed bits hold about +-500M votes before any wrap
    parameter int def_acc_width = 30;

    // one signed vote holds -1, 0 or +1
    parameter int vote_width = 2;

    // signed width for a sum of group_size votes
    // range is -group_size .. +group_size, plus one sign bit
    function automatic int group_sum_width(input int group_size);
        return $clog2(group_size + 1) + 1;
    endfunction

endpackage

// File: verilog/vote_types_pkg.sv
package vote_types_pkg;

    // control bits that ride alongside one batch
    // valid marks a real batch in this pipeline slot
    // last closes a run and asks for a result
    typedef struct packed {
        logic valid;
        logic last;
    } batch_ctrl_t;

    // reported answer of a run
    // valid is a one-cycle pulse
    // sign is set for a negative sum
    // zero is set when the sum is exactly zero
    typedef struct packed {
        logic valid;
        logic sign;
        logic zero;
    } result_t;

endpackage

// File: verilog/vote_decode.sv
`timescale 1ns/1ps

module vote_decode #(
    parameter int core_num = vote_cfg_pkg::def_core_num
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            batch_valid,
    input  logic                                            batch_last,
    // mask of cores that report this cycle
    input  logic [core_num-1:0]                             store,
    input  logic [core_num-1:0]                             core_result,
    output vote_types_pkg::batch_ctrl_t                     ctrl,
    output logic signed [vote_cfg_pkg::vote_width-1:0]      votes [core_num]
);

    import vote_cfg_pkg::*;

    // vote encodings
    localparam logic signed [vote_width-1:0] vote_up   = vote_width'(1);
    localparam logic signed [vote_width-1:0] vote_down = -vote_width'(1);
    localparam logic signed [vote_width-1:0] vote_none = '0;

    // control travels with the batch
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl <= '0;
        end else begin
            ctrl.valid <= batch_valid;
            ctrl.last  <= batch_valid & batch_last;
        end
    end

    // one vote per core, sampled every cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < core_num; i++) begin
            if (!batch_valid || !store[i]) begin
                // idle slot or silent core
                votes[i] <= vote_none;
            end else if (core_result[i]) begin
                votes[i] <= vote_up;
            end else begin
                // reported 0 counts against
                votes[i] <= vote_down;
            end
        end
    end

endmodule

// File: verilog/vote_group_sum.sv
`timescale 1ns/1ps

module vote_group_sum #(
    parameter int core_num   = vote_cfg_pkg::def_core_num,
    parameter int group_size = vote_cfg_pkg::def_group_size
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  vote_types_pkg::batch_ctrl_t                 ctrl_in,
    input  logic signed [vote_cfg_pkg::vote_width-1:0]  votes [core_num],
    output vote_types_pkg::batch_ctrl_t                 ctrl_out,
    output logic signed [vote_cfg_pkg::group_sum_width(group_size)-1:0]
                                                        sums [core_num/group_size]
);

    import vote_cfg_pkg::*;

    // number of adder groups
    localparam int group_num = core_num / group_size;
    // signed width of one partial sum
    localparam int sum_w = group_sum_width(group_size);

    // control follows the partial sums by one stage
    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_out <= '0;
        end else begin
            ctrl_out <= ctrl_in;
        end
    end

    // one adder per group of consecutive cores
    for (genvar g = 0; g < group_num; g++) begin : g_group
        logic signed [sum_w-1:0] group_total;

        // sign-extend each vote before adding
        always_comb begin
            group_total = '0;
            for (int k = 0; k < group_size; k++) begin
                group_total = group_total + sum_w'(votes[g*group_size + k]);
            end
        end

        // partial sum register
        // idle slots carry zero votes, so no gating here
        always_ff @(posedge clk) begin
            sums[g] <= group_total;
        end
    end

endmodule

// File: verilog/vote_accumulate.sv
`timescale 1ns/1ps

module vote_accumulate #(
    parameter int core_num   = vote_cfg_pkg::def_core_num,
    parameter int group_size = vote_cfg_pkg::def_group_size,
    parameter int acc_width  = vote_cfg_pkg::def_acc_width
) (
    input  logic                                        clk,
    input  logic                                        rst,
    // restart strobe, bias chosen by even and tie_bit
    input  logic                                        clear,
    input  logic                                        even,
    input  logic                                        tie_bit,
    input  vote_types_pkg::batch_ctrl_t                 ctrl_in,
    input  logic signed [vote_cfg_pkg::group_sum_width(group_size)-1:0]
                                                        sums [core_num/group_size],
    output vote_types_pkg::batch_ctrl_t                 ctrl_out,
    output logic signed [acc_width-1:0]                 acc_value
);

    import vote_cfg_pkg::*;

    localparam int group_num = core_num / group_size;

    logic signed [acc_width-1:0] batch_total;
    logic signed [acc_width-1:0] bias;

    // add all partial sums at full accumulator width
    always_comb begin
        batch_total = '0;
        for (int g = 0; g < group_num; g++) begin
            batch_total = batch_total + acc_width'(sums[g]);
        end
    end

    // preload value on clear
    // an odd start keeps an even vote count off zero
    always_comb begin
        if (!even) begin
            bias = '0;
        end else if (tie_bit) begin
            // all ones is -1
            bias = '1;
        end else begin
            bias = acc_width'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl_out  <= '0;
            acc_value <= '0;
        end else begin
            // ctrl lines up with the updated sum
            ctrl_out <= ctrl_in;
            if (clear) begin
                acc_value <= bias;
            end else if (ctrl_in.valid) begin
                acc_value <= acc_value + batch_total;
            end
        end
    end

endmodule

// File: verilog/vote_result.sv
`timescale 1ns/1ps

module vote_result #(
    parameter int acc_width = vote_cfg_pkg::def_acc_width
) (
    input  logic                            clk,
    input  logic                            rst,
    input  vote_types_pkg::batch_ctrl_t     ctrl_in,
    // running sum including the batch in ctrl_in
    input  logic signed [acc_width-1:0]     acc_value,
    output vote_types_pkg::result_t         res
);

    logic acc_neg;
    logic acc_zero;
    logic run_done;

    // top bit of the two's complement sum
    assign acc_neg  = acc_value[acc_width-1];
    assign acc_zero = (acc_value == '0);

    // last batch of the run has reached the accumulator
    assign run_done = ctrl_in.valid & ctrl_in.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            // sign and zero read low until the first answer
            res <= '0;
        end else begin
            res.valid <= run_done;
            if (run_done) begin
                res.sign <= acc_neg;
                res.zero <= acc_zero;
            end
            // otherwise hold the previous answer
        end
    end

endmodule

// File: verilog/vote_counter.sv
`timescale 1ns/1ps

module vote_counter #(
    parameter int core_num   = vote_cfg_pkg::def_core_num,
    parameter int group_size = vote_cfg_pkg::def_group_size,
    parameter int acc_width  = vote_cfg_pkg::def_acc_width
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        clear,
    input  logic                        even,
    input  logic                        tie_bit,
    input  logic                        batch_valid,
    input  logic                        batch_last,
    input  logic [core_num-1:0]         store,
    input  logic [core_num-1:0]         core_result,
    output logic                        result_valid,
    output logic                        sign_bit,
    output logic                        zero,
    output logic signed [acc_width-1:0] sum
);

    import vote_cfg_pkg::*;
    import vote_types_pkg::*;

    localparam int group_num = core_num / group_size;
    localparam int sum_w     = group_sum_width(group_size);

    // decode to execute
    batch_ctrl_t                    dec_ctrl;
    logic signed [vote_width-1:0]   dec_votes [core_num];

    // group adders to accumulator
    batch_ctrl_t                    grp_ctrl;
    logic signed [sum_w-1:0]        grp_sums [group_num];

    // accumulator to result
    batch_ctrl_t                    acc_ctrl;
    logic signed [acc_width-1:0]    acc_value;

    result_t                        res;

    // decode, votes land at E
    vote_decode #(
        .core_num (core_num)
    ) u_decode (
        .clk         (clk),
        .rst         (rst),
        .batch_valid (batch_valid),
        .batch_last  (batch_last),
        .store       (store),
        .core_result (core_result),
        .ctrl        (dec_ctrl),
        .votes       (dec_votes)
    );

    // execute first half, partial sums at E+1
    vote_group_sum #(
        .core_num   (core_num),
        .group_size (group_size)
    ) u_group_sum (
        .clk      (clk),
        .rst      (rst),
        .ctrl_in  (dec_ctrl),
        .votes    (dec_votes),
        .ctrl_out (grp_ctrl),
        .sums     (grp_sums)
    );

    // execute second half, sum at E+2
    vote_accumulate #(
        .core_num   (core_num),
        .group_size (group_size),
        .acc_width  (acc_width)
    ) u_accumulate (
        .clk       (clk),
        .rst       (rst),
        .clear     (clear),
        .even      (even),
        .tie_bit   (tie_bit),
        .ctrl_in   (grp_ctrl),
        .sums      (grp_sums),
        .ctrl_out  (acc_ctrl),
        .acc_value (acc_value)
    );

    // result pulse at E+3
    vote_result #(
        .acc_width (acc_width)
    ) u_result (
        .clk       (clk),
        .rst       (rst),
        .ctrl_in   (acc_ctrl),
        .acc_value (acc_value),
        .res       (res)
    );

    assign result_valid = res.valid;
    assign sign_bit     = res.sign;
    assign zero         = res.zero;
    assign sum          = acc_value;

endmodule

// File: verif/vote_counter_tb.sv
`timescale 1ns/1ps

module vote_counter_tb;

    import vote_cfg_pkg::*;

    localparam int core_num   = def_core_num;
    localparam int group_size = def_group_size;
    localparam int acc_width  = def_acc_width;

    // run lengths
    localparam int reset_cycles = 10;
    localparam int n_random     = 20;
    localparam int n_b2b        = 30;
    localparam int n_neg        = 10;
    localparam int result_wait  = 8;
    localparam int clear_len    = 4;
    // 6 clears, 7 result waits, plus idle start and single batches
    localparam int total_cycles = reset_cycles + 5 + 6 * clear_len + 7 * result_wait
                                  + 4 + n_random + n_b2b + n_neg;
    localparam int margin_ns    = 200;

    // one batch on its way through the model pipeline
    typedef struct packed {
        logic signed [31:0] delta;
        logic               valid;
        logic               last;
    } batch_entry_t;

    logic                        clk = 1'b0;
    logic                        rst;
    logic                        clear;
    logic                        even;
    logic                        tie_bit;
    logic                        batch_valid;
    logic                        batch_last;
    logic [core_num-1:0]         store;
    logic [core_num-1:0]         core_result;
    logic                        result_valid;
    logic                        sign_bit;
    logic                        zero;
    logic signed [acc_width-1:0] sum;

    // model state
    batch_entry_t                model_q [$];
    int                          model_acc;
    logic                        pend_result;
    logic                        pend_sign;
    logic                        pend_zero;
    logic signed [acc_width-1:0] exp_sum;
    logic                        exp_valid;
    logic                        exp_sign;
    logic                        exp_zero;

    int err_sum;
    int err_valid;
    int err_sign;
    int err_zero;
    int err_other;
    int last_count;
    int pulse_count;

    always #4 clk = ~clk;

    vote_counter #(
        .core_num   (core_num),
        .group_size (group_size),
        .acc_width  (acc_width)
    ) dut (
        .clk          (clk),
        .rst          (rst),
        .clear        (clear),
        .even         (even),
        .tie_bit      (tie_bit),
        .batch_valid  (batch_valid),
        .batch_last   (batch_last),
        .store        (store),
        .core_result  (core_result),
        .result_valid (result_valid),
        .sign_bit     (sign_bit),
        .zero         (zero),
        .sum          (sum)
    );

    // stored ones count up, stored zeros count down
    function automatic int vote_delta(input logic [core_num-1:0] mask,
                                      input logic [core_num-1:0] bits);
        int total;
        total = 0;
        for (int i = 0; i < core_num; i++) begin
            if (mask[i]) begin
                total += bits[i] ? 1 : -1;
            end
        end
        return total;
    endfunction

    function automatic int bias_value(input logic even_v, input logic tie_v);
        if (!even_v) begin
            return 0;
        end
        return tie_v ? -1 : 1;
    endfunction

    function automatic int total_errors();
        return err_sum + err_valid + err_sign + err_zero + err_other;
    endfunction

    // reference model, updates on the same edge as the DUT registers
    always @(posedge clk) begin : ref_model
        batch_entry_t entry;
        batch_entry_t head;
        if (rst) begin
            model_q.delete();
            model_acc   = 0;
            pend_result = 1'b0;
            pend_sign   = 1'b0;
            pend_zero   = 1'b0;
            exp_sum    <= '0;
            exp_valid  <= 1'b0;
            exp_sign   <= 1'b0;
            exp_zero   <= 1'b0;
        end else begin
            // answer shows one edge after the last batch lands
            exp_valid <= pend_result;
            if (pend_result) begin
                exp_sign <= pend_sign;
                exp_zero <= pend_zero;
            end
            entry.delta = batch_valid ? vote_delta(store, core_result) : 0;
            entry.valid = batch_valid;
            entry.last  = batch_valid & batch_last;
            model_q.push_back(entry);
            pend_result = 1'b0;
            if (clear) begin
                model_acc = bias_value(even, tie_bit);
            end
            // batch sampled two edges ago reaches the sum now
            if (model_q.size() > 2) begin
                head = model_q.pop_front();
                if (!clear && head.valid) begin
                    model_acc += head.delta;
                end
                pend_result = head.valid & head.last;
                pend_sign   = (model_acc < 0);
                pend_zero   = (model_acc == 0);
            end
            exp_sum <= acc_width'(model_acc);
        end
    end

    // outputs are compared half a cycle after they settle
    sum_check: assert property (@(negedge clk) disable iff (rst) sum == exp_sum)
        else begin
            err_sum++;
            $display("Mismatch at %0t: sum expected %0d, got %0d", $time, exp_sum, sum);
        end

    valid_check: assert property (@(negedge clk) disable iff (rst)
                                  result_valid == exp_valid)
        else begin
            err_valid++;
            $display("Mismatch at %0t: result_valid expected %0b, got %0b",
                     $time, exp_valid, result_valid);
        end

    sign_check: assert property (@(negedge clk) disable iff (rst) sign_bit == exp_sign)
        else begin
            err_sign++;
            $display("Mismatch at %0t: sign_bit expected %0b, got %0b",
                     $time, exp_sign, sign_bit);
        end

    zero_check: assert property (@(negedge clk) disable iff (rst) zero == exp_zero)
        else begin
            err_zero++;
            $display("Mismatch at %0t: zero expected %0b, got %0b", $time, exp_zero, zero);
        end

    // result pulses, one per last batch
    always @(negedge clk) begin
        if (!rst && result_valid) begin
            pulse_count++;
        end
    end

    task automatic drive_idle();
        clear       = 1'b0;
        even        = 1'b0;
        tie_bit     = 1'b0;
        batch_valid = 1'b0;
        batch_last  = 1'b0;
        store       = '0;
        core_result = '0;
    endtask

    task automatic send_batch(input logic [core_num-1:0] mask,
                              input logic [core_num-1:0] bits,
                              input logic last);
        @(negedge clk);
        clear       = 1'b0;
        batch_valid = 1'b1;
        batch_last  = last;
        store       = mask;
        core_result = bits;
        if (last) begin
            last_count++;
        end
    endtask

    // three quiet cycles so nothing is in flight at the clear edge
    task automatic restart_sum(input logic even_v, input logic tie_v);
        repeat (3) begin
            @(negedge clk);
            drive_idle();
        end
        @(negedge clk);
        drive_idle();
        clear   = 1'b1;
        even    = even_v;
        tie_bit = tie_v;
    endtask

    task automatic wait_result();
        int waited;
        waited = 0;
        do begin
            @(negedge clk);
            drive_idle();
            waited++;
        end while (!result_valid && waited < result_wait);
        if (!result_valid) begin
            err_other++;
            $display("no result pulse within %0d cycles at %0t", result_wait, $time);
        end
    endtask

    // hang guard
    initial begin
        #(total_cycles * 8 + margin_ns);
        $display("watchdog expired at %0t, the test sequence did not finish", $time);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        logic [core_num-1:0] bits;
        void'($urandom(58));
        err_sum     = 0;
        err_valid   = 0;
        err_sign    = 0;
        err_zero    = 0;
        err_other   = 0;
        last_count  = 0;
        pulse_count = 0;
        rst         = 1'b1;
        drive_idle();
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;

        // quiet after reset, sum stays zero
        repeat (5) @(negedge clk);

        // single last batch, every core reporting
        send_batch('1, core_num'($urandom), 1'b1);
        wait_result();

        // random masks and results
        restart_sum(1'b0, 1'b0);
        for (int i = 0; i < n_random; i++) begin
            send_batch(core_num'($urandom), core_num'($urandom), i == n_random - 1);
        end
        wait_result();

        // bias variants, each followed by a tied batch
        restart_sum(1'b1, 1'b0);
        send_batch('1, {core_num/2{2'b01}}, 1'b1);
        wait_result();
        restart_sum(1'b1, 1'b1);
        send_batch('1, {core_num/2{2'b01}}, 1'b1);
        wait_result();
        restart_sum(1'b0, 1'b1);
        send_batch('1, {core_num/2{2'b01}}, 1'b1);
        wait_result();

        // back to back, no idle slots
        restart_sum(1'b1, 1'($urandom));
        for (int i = 0; i < n_b2b; i++) begin
            send_batch(core_num'($urandom), core_num'($urandom), i == n_b2b - 1);
        end
        wait_result();

        // mostly zero votes, sparse ones
        restart_sum(1'b0, 1'b0);
        for (int i = 0; i < n_neg; i++) begin
            bits = core_num'($urandom & $urandom & $urandom);
            send_batch('1, bits, i == n_neg - 1);
        end
        wait_result();
        negative_check: assert (sign_bit)
            else begin
                err_sign++;
                $display("Mismatch at %0t: sign_bit expected 1, got %0b", $time, sign_bit);
            end

        repeat (4) @(negedge clk);
        pulse_check: assert (pulse_count == last_count)
            else begin
                err_other++;
                $display("saw %0d result pulses for %0d last batches",
                         pulse_count, last_count);
            end

        $display("errors: sum %0d, result_valid %0d, sign_bit %0d, zero %0d, other %0d",
                 err_sum, err_valid, err_sign, err_zero, err_other);
        if (total_errors() == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: vote_counter.f
verilog/vote_cfg_pkg.sv
verilog/vote_types_pkg.sv
verilog/vote_decode.sv
verilog/vote_group_sum.sv
verilog/vote_accumulate.sv
verilog/vote_result.sv
verilog/vote_counter.sv
verif/vote_counter_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the vote counter testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module vote_counter_tb \
    -Mdir obj_dir \
    -f vote_counter.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vvote_counter_tb)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the verdict line stands alone in the output
if printf '%s\n' "$output" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi

echo "pass line not found in simulation output"
exit 1
